// ==== icache_defs.svh ====
// cache geometry and bus widths, included by the package and by the testbench
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// associativity of the cache
`define ICACHE_WAYS 4

// number of sets, one line per way in each set
`define ICACHE_SETS 64

// a refill line is transferred in a single return beat
`define ICACHE_LINE_BITS 128

// width of one fetched instruction word
`define ICACHE_FETCH_BITS 32

// physical address width
// the upper half of the address space is the I/O region
`define ICACHE_PADDR_BITS 32

`endif

// ==== icache_pkg.sv ====
// shared instruction cache types, referenced by scoped name from the design files
`default_nettype none

`include "icache_defs.svh"

package icache_pkg;

  //////////////////////////////
  // address fields
  //////////////////////////////

  // physical fetch address
  typedef logic [`ICACHE_PADDR_BITS-1:0] paddr_t;

  // set index sits right above the line offset
  typedef logic [$clog2(`ICACHE_SETS)-1:0] index_t;

  // byte offset inside a line
  typedef logic [$clog2(`ICACHE_LINE_BITS/8)-1:0] offset_t;

  // remaining upper address bits
  typedef logic [`ICACHE_PADDR_BITS-$clog2(`ICACHE_SETS)-$clog2(`ICACHE_LINE_BITS/8)-1:0] tag_t;

  //////////////////////////////
  // payloads and way vectors
  //////////////////////////////

  typedef logic [`ICACHE_LINE_BITS-1:0] line_t;
  typedef logic [`ICACHE_FETCH_BITS-1:0] word_t;
  typedef logic [`ICACHE_WAYS-1:0] way_oh_t;
  typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_idx_t;

  // one entry of the tag memory
  typedef struct packed {
    logic valid;
    tag_t tag;
  } tag_entry_t;

  // kind of packet on the return port
  typedef enum logic {
    IFILL,
    INV
  } rtrn_type_e;

  // controller states
  typedef enum logic [1:0] {
    FLUSH,
    IDLE,
    READ,
    MISS
  } ctrl_state_e;

endpackage

`default_nettype wire

// ==== icache_array_if.sv ====
// array command bundle, driven by the cache controller and sampled by the way memories
`timescale 1ns/10ps
`default_nettype none

interface icache_array_if;

  // tag and valid memories, one request bit per way
  icache_pkg::way_oh_t tag_req;
  logic                tag_we;
  icache_pkg::index_t  tag_addr;
  // valid bit stored along with wtag on a write
  logic                tag_wdata_valid;
  icache_pkg::tag_t    wtag;

  // line memories
  icache_pkg::way_oh_t data_req;
  logic                data_we;
  icache_pkg::index_t  data_addr;

  // byte offset of the word picked from a hitting line
  icache_pkg::offset_t rd_offset;

  modport ctrl_mp (
    output tag_req, tag_we, tag_addr, tag_wdata_valid, wtag,
    output data_req, data_we, data_addr, rd_offset
  );

  modport array_mp (
    input tag_req, tag_we, tag_addr, tag_wdata_valid, wtag,
    input data_req, data_we, data_addr, rd_offset
  );

endinterface

`default_nettype wire

// ==== icache_sram.sv ====
// single-port memory with registered read, instantiated for tag entries and for cache lines
`timescale 1ns/10ps
`default_nettype none

module icache_sram #(
  parameter type entry_t   = logic,
  parameter int  NUM_WORDS = 64
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_i,
  input  logic               we_i,
  input  icache_pkg::index_t addr_i,
  input  entry_t             wdata_i,
  output entry_t             rdata_o
);

  // storage array, contents are undefined until written
  entry_t mem_q [NUM_WORDS];

  always_ff @(posedge clk_i) begin : p_write
    if (req_i && we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
  end

  // read data shows up the cycle after the request
  // and holds while the port is idle or writing
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_read
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i && !we_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

`default_nettype wire

// ==== icache_ways.sv ====
// per-way tag and line memories with tag compare and hit word selection for the cache controller
`timescale 1ns/10ps
`default_nettype none

`include "icache_defs.svh"

module icache_ways (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  icache_array_if.array_mp     arr_if,
  input  icache_pkg::tag_t     cmp_tag_i,
  input  logic                 cmp_en_i,
  input  icache_pkg::line_t    fill_line_i,
  output icache_pkg::way_oh_t  hit_o,
  output icache_pkg::word_t    hit_word_o,
  output icache_pkg::way_oh_t  valid_bits_o
);

  icache_pkg::tag_entry_t tag_wdata;
  icache_pkg::tag_entry_t tag_rdata [`ICACHE_WAYS];
  icache_pkg::line_t      line_rdata [`ICACHE_WAYS];
  icache_pkg::word_t      way_word [`ICACHE_WAYS];

  // same entry goes to every way selected by tag_req
  assign tag_wdata.valid = arr_if.tag_wdata_valid;
  assign tag_wdata.tag   = arr_if.wtag;

  //////////////////////////////
  // memories and compare
  //////////////////////////////

  for (genvar i = 0; i < `ICACHE_WAYS; i++) begin : gen_way
    icache_sram #(
      .entry_t   (icache_pkg::tag_entry_t),
      .NUM_WORDS (`ICACHE_SETS)
    ) i_tag_sram (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (arr_if.tag_req[i]),
      .we_i    (arr_if.tag_we),
      .addr_i  (arr_if.tag_addr),
      .wdata_i (tag_wdata),
      .rdata_o (tag_rdata[i])
    );

    // fill data comes straight from the return port
    icache_sram #(
      .entry_t   (icache_pkg::line_t),
      .NUM_WORDS (`ICACHE_SETS)
    ) i_data_sram (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (arr_if.data_req[i]),
      .we_i    (arr_if.data_we),
      .addr_i  (arr_if.data_addr),
      .wdata_i (fill_line_i),
      .rdata_o (line_rdata[i])
    );

    assign valid_bits_o[i] = tag_rdata[i].valid;

    // the controller blanks the compare for NC lookups and after invalidations
    assign hit_o[i] = cmp_en_i & tag_rdata[i].valid & (tag_rdata[i].tag == cmp_tag_i);

    // word at the registered byte offset
    assign way_word[i] = line_rdata[i][{arr_if.rd_offset, 3'b000} +: `ICACHE_FETCH_BITS];
  end

  //////////////////////////////
  // hit word select
  //////////////////////////////

  // lowest hitting way wins, a single hit is the normal case
  always_comb begin : p_hit_sel
    hit_word_o = way_word[0];
    for (int i = `ICACHE_WAYS - 1; i >= 0; i--) begin
      if (hit_o[i]) begin
        hit_word_o = way_word[i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== icache_repl.sv ====
// replacement way choice for refills, first invalid way or a pseudo-random way when the set is full
`timescale 1ns/10ps
`default_nettype none

module icache_repl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  icache_pkg::way_oh_t   valid_bits_i,
  input  logic                  cmp_en_i,
  input  logic                  fill_i,
  output icache_pkg::way_idx_t  repl_way_o,
  output icache_pkg::way_oh_t   repl_way_oh_o
);

  logic [7:0]           lfsr_q;
  icache_pkg::way_idx_t inv_way;
  logic                 all_valid;

  // scan from the top so the lowest invalid way is kept
  always_comb begin : p_first_invalid
    inv_way   = '0;
    all_valid = 1'b1;
    for (int i = $bits(icache_pkg::way_oh_t) - 1; i >= 0; i--) begin
      if (!valid_bits_i[i]) begin
        inv_way   = icache_pkg::way_idx_t'(i);
        all_valid = 1'b0;
      end
    end
  end

  assign repl_way_o = all_valid ? lfsr_q[$bits(icache_pkg::way_idx_t)-1:0] : inv_way;

  // maximal length 8-bit lfsr, taps 8 6 5 4
  // advances once per line fill
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_lfsr
    if (!rst_ni) begin
      lfsr_q <= 8'hA5;
    end else if (fill_i) begin
      lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
    end
  end

  // capture the choice while the lookup result is fresh
  // the refill writes this way later
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_repl_oh
    if (!rst_ni) begin
      repl_way_oh_o <= '0;
    end else if (cmp_en_i) begin
      repl_way_oh_o <= icache_pkg::way_oh_t'(1) << repl_way_o;
    end
  end

endmodule

`default_nettype wire

// ==== icache_ctrl.sv ====
// instruction cache controller with the fetch FSM, flush sequencer, array steering and refill port
`timescale 1ns/10ps
`default_nettype none

`include "icache_defs.svh"

module icache_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    en_i,
  input  logic                    flush_i,
  input  logic                    req_i,
  input  icache_pkg::paddr_t      addr_i,
  output logic                    ready_o,
  output logic                    valid_o,
  output logic                    busy_o,
  output logic                    miss_o,
  icache_array_if.ctrl_mp         arr_if,
  input  icache_pkg::way_oh_t     hit_i,
  input  icache_pkg::word_t       hit_word_i,
  output icache_pkg::tag_t        cmp_tag_o,
  output logic                    cmp_en_o,
  input  icache_pkg::way_idx_t    repl_way_i,
  input  icache_pkg::way_oh_t     repl_way_oh_i,
  output logic                    fill_o,
  output logic                    mem_req_o,
  input  logic                    mem_ack_i,
  output icache_pkg::paddr_t      mem_paddr_o,
  output logic                    mem_nc_o,
  output icache_pkg::way_idx_t    mem_way_o,
  input  logic                    mem_rtrn_vld_i,
  input  icache_pkg::rtrn_type_e  mem_rtrn_type_i,
  input  icache_pkg::line_t       mem_rtrn_data_i,
  input  logic                    mem_inv_all_i,
  input  logic                    mem_inv_vld_i,
  input  icache_pkg::index_t      mem_inv_idx_i,
  input  icache_pkg::way_idx_t    mem_inv_way_i,
  output icache_pkg::word_t       data_o
);

  localparam int OFF_W = $bits(icache_pkg::offset_t);
  localparam int IDX_W = $bits(icache_pkg::index_t);
  localparam int MSB   = `ICACHE_PADDR_BITS - 1;

  icache_pkg::ctrl_state_e state_d, state_q;
  icache_pkg::paddr_t      addr_d, addr_q;
  icache_pkg::index_t      flush_cnt_d, flush_cnt_q;
  icache_pkg::index_t      index_d;
  icache_pkg::offset_t     offset_q;
  icache_pkg::way_oh_t     inv_way_oh;
  logic cache_en_d, cache_en_q;
  logic flush_d, flush_q;
  logic cmp_en_d, cmp_en_q;
  logic inv_q;
  logic rst_done_q;
  logic lookup;
  logic cache_rden;
  logic cache_wren;
  logic flush_en;
  logic flush_done;
  logic inv_en;
  logic paddr_is_nc;

  //////////////////////////////
  // address plumbing
  //////////////////////////////

  // a taken request replaces the held address
  assign addr_d   = (ready_o && req_i) ? addr_i : addr_q;
  assign index_d  = addr_d[OFF_W +: IDX_W];
  // fetches are 32-bit aligned
  assign offset_q = {addr_q[OFF_W-1:2], 2'b00};

  // I/O region and a disabled cache both take the NC path
  assign paddr_is_nc = ~cache_en_q | addr_q[MSB];

  // NC reads fetch one word, cacheable misses a whole line
  assign mem_paddr_o = paddr_is_nc ? {addr_q[MSB:2], 2'b00} :
                                     {addr_q[MSB:OFF_W], {OFF_W{1'b0}}};
  assign mem_nc_o    = paddr_is_nc;
  assign mem_way_o   = repl_way_i;

  assign cmp_tag_o = addr_q[MSB -: $bits(icache_pkg::tag_t)];
  assign cmp_en_o  = cmp_en_q;
  assign fill_o    = cache_wren;
  assign busy_o    = (state_q != icache_pkg::IDLE);

  // an NC return carries the word in every slot, so the offset select works for both
  assign data_o = cmp_en_q ? hit_word_i : mem_rtrn_data_i[{offset_q, 3'b000} +: `ICACHE_FETCH_BITS];

  // invalidations are consumed whenever they arrive
  assign inv_en = mem_rtrn_vld_i & (mem_rtrn_type_i == icache_pkg::INV);

  // compare only in the cycle after a cacheable lookup read
  assign cmp_en_d = lookup & cache_en_q & ~addr_d[MSB];

  //////////////////////////////
  // main FSM
  //////////////////////////////

  always_comb begin : p_fsm
    state_d    = state_q;
    cache_en_d = cache_en_q & en_i;
    flush_d    = flush_q | flush_i;
    flush_en   = 1'b0;
    lookup     = 1'b0;
    cache_rden = 1'b0;
    cache_wren = 1'b0;
    ready_o    = 1'b0;
    valid_o    = 1'b0;
    mem_req_o  = 1'b0;
    miss_o     = 1'b0;

    unique case (state_q)
      // clear one set per cycle
      icache_pkg::FLUSH: begin
        flush_en = 1'b1;
        if (flush_done) begin
          state_d    = icache_pkg::IDLE;
          flush_d    = 1'b0;
          cache_en_d = en_i;
        end
      end
      icache_pkg::IDLE: begin
        lookup = 1'b1;
        // enabling always starts from an empty cache
        if (flush_d || (en_i && !cache_en_q)) begin
          state_d = icache_pkg::FLUSH;
        end else if (rst_done_q && !mem_rtrn_vld_i) begin
          ready_o = 1'b1;
          if (req_i) begin
            cache_rden = cache_en_q;
            state_d    = icache_pkg::READ;
          end
        end
      end
      // result of the lookup, or miss/NC request
      icache_pkg::READ: begin
        lookup     = 1'b1;
        // arrays are read again every cycle so an invalidation is seen
        cache_rden = cache_en_q;
        if (|hit_i && !inv_q) begin
          valid_o = 1'b1;
          state_d = icache_pkg::IDLE;
          // pipeline the next request unless a return or flush is pending
          if (!mem_rtrn_vld_i && !flush_d) begin
            ready_o = 1'b1;
            if (req_i) begin
              state_d = icache_pkg::READ;
            end
          end
        end else if (!inv_q) begin
          lookup    = 1'b0;
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = ~paddr_is_nc;
            state_d = icache_pkg::MISS;
          end
        end
      end
      // wait for the refill, NC data never lands in the arrays
      icache_pkg::MISS: begin
        if (mem_rtrn_vld_i && mem_rtrn_type_i == icache_pkg::IFILL) begin
          valid_o    = 1'b1;
          cache_wren = ~paddr_is_nc;
          state_d    = icache_pkg::IDLE;
        end
      end
      default: begin
        state_d = icache_pkg::IDLE;
      end
    endcase
  end

  //////////////////////////////
  // array steering
  //////////////////////////////

  assign flush_done  = (flush_cnt_q == icache_pkg::index_t'(`ICACHE_SETS - 1));
  assign flush_cnt_d = flush_done ? '0 :
                       flush_en   ? flush_cnt_q + 1'b1 :
                                    flush_cnt_q;

  assign inv_way_oh = icache_pkg::way_oh_t'(1) << mem_inv_way_i;

  // flush counter over invalidation over lookup
  assign arr_if.tag_addr = flush_en ? flush_cnt_q :
                           inv_en   ? mem_inv_idx_i :
                                      index_d;

  always_comb begin : p_tag_mask
    if (flush_en) begin
      arr_if.tag_req = '1;
    end else if (inv_en) begin
      arr_if.tag_req = mem_inv_all_i ? '1 : (mem_inv_vld_i ? inv_way_oh : '0);
    end else if (cache_rden) begin
      arr_if.tag_req = '1;
    end else if (cache_wren) begin
      arr_if.tag_req = repl_way_oh_i;
    end else begin
      arr_if.tag_req = '0;
    end
  end

  // only a fill sets a valid bit
  assign arr_if.tag_we          = flush_en | inv_en | cache_wren;
  assign arr_if.tag_wdata_valid = cache_wren;
  assign arr_if.wtag            = cmp_tag_o;

  assign arr_if.data_req  = cache_rden ? '1 : (cache_wren ? repl_way_oh_i : '0);
  assign arr_if.data_we   = cache_wren;
  assign arr_if.data_addr = index_d;
  assign arr_if.rd_offset = offset_q;

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q     <= icache_pkg::IDLE;
      flush_cnt_q <= '0;
      cache_en_q  <= 1'b0;
      flush_q     <= 1'b0;
      cmp_en_q    <= 1'b0;
      inv_q       <= 1'b0;
      rst_done_q  <= 1'b0;
    end else begin
      state_q     <= state_d;
      flush_cnt_q <= flush_cnt_d;
      cache_en_q  <= cache_en_d;
      flush_q     <= flush_d;
      cmp_en_q    <= cmp_en_d;
      // a hit in the cycle after an invalidation is not trusted
      inv_q       <= inv_en;
      // requests are taken from the second cycle after reset
      rst_done_q  <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin : p_addr
    addr_q <= addr_d;
  end

endmodule

`default_nettype wire

// ==== icache_top.sv ====
// instruction cache top level with one fetch port and one refill and invalidation port
`timescale 1ns/10ps
`default_nettype none

module icache_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    en_i,
  input  logic                    flush_i,
  output logic                    busy_o,
  output logic                    miss_o,
  // fetch port
  input  logic                    req_i,
  input  icache_pkg::paddr_t      addr_i,
  output logic                    ready_o,
  output logic                    valid_o,
  output icache_pkg::word_t       data_o,
  // refill request
  output logic                    mem_req_o,
  input  logic                    mem_ack_i,
  output icache_pkg::paddr_t      mem_paddr_o,
  output logic                    mem_nc_o,
  output icache_pkg::way_idx_t    mem_way_o,
  // fills and invalidations
  input  logic                    mem_rtrn_vld_i,
  input  icache_pkg::rtrn_type_e  mem_rtrn_type_i,
  input  icache_pkg::line_t       mem_rtrn_data_i,
  input  logic                    mem_inv_all_i,
  input  logic                    mem_inv_vld_i,
  input  icache_pkg::index_t      mem_inv_idx_i,
  input  icache_pkg::way_idx_t    mem_inv_way_i
);

  icache_pkg::way_oh_t  hit;
  icache_pkg::word_t    hit_word;
  icache_pkg::way_oh_t  valid_bits;
  icache_pkg::tag_t     cmp_tag;
  logic                 cmp_en;
  icache_pkg::way_idx_t repl_way;
  icache_pkg::way_oh_t  repl_way_oh;
  logic                 fill;

  icache_array_if arr_if ();

  // remaining ports share their names with the top level
  icache_ctrl i_ctrl (
    .arr_if        (arr_if),
    .hit_i         (hit),
    .hit_word_i    (hit_word),
    .cmp_tag_o     (cmp_tag),
    .cmp_en_o      (cmp_en),
    .repl_way_i    (repl_way),
    .repl_way_oh_i (repl_way_oh),
    .fill_o        (fill),
    .*
  );

  // fill lines are written straight from the return port
  icache_ways i_ways (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .arr_if       (arr_if),
    .cmp_tag_i    (cmp_tag),
    .cmp_en_i     (cmp_en),
    .fill_line_i  (mem_rtrn_data_i),
    .hit_o        (hit),
    .hit_word_o   (hit_word),
    .valid_bits_o (valid_bits)
  );

  icache_repl i_repl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .valid_bits_i  (valid_bits),
    .cmp_en_i      (cmp_en),
    .fill_i        (fill),
    .repl_way_o    (repl_way),
    .repl_way_oh_o (repl_way_oh)
  );

endmodule

`default_nettype wire

// ==== tb_icache.sv ====
// self-checking testbench for the instruction cache, drives icache_top from a table of rows
`timescale 1ns/10ps
`default_nettype none

`include "icache_defs.svh"

module tb_icache;

  // fill words are their own byte address scrambled with this key
  localparam icache_pkg::word_t MODEL_KEY = 32'h5A3C_96E1;

  typedef enum int {K_FETCH, K_ENABLE, K_DISABLE, K_FLUSH, K_INV_WAY, K_INV_ALL} kind_e;
  typedef enum int {E_NONE, E_HIT, E_MISS, E_NC, E_ANY} outcome_e;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   en_i;
  logic                   flush_i;
  logic                   busy_o;
  logic                   miss_o;
  logic                   req_i;
  icache_pkg::paddr_t     addr_i;
  logic                   ready_o;
  logic                   valid_o;
  icache_pkg::word_t      data_o;
  logic                   mem_req_o;
  logic                   mem_ack_i;
  icache_pkg::paddr_t     mem_paddr_o;
  logic                   mem_nc_o;
  icache_pkg::way_idx_t   mem_way_o;
  logic                   mem_rtrn_vld_i;
  icache_pkg::rtrn_type_e mem_rtrn_type_i;
  icache_pkg::line_t      mem_rtrn_data_i;
  logic                   mem_inv_all_i;
  logic                   mem_inv_vld_i;
  icache_pkg::index_t     mem_inv_idx_i;
  icache_pkg::way_idx_t   mem_inv_way_i;

  // stimulus table with one entry per row in each queue
  kind_e              row_kind [$];
  icache_pkg::paddr_t row_addr [$];
  outcome_e           row_exp [$];

  // refill way of each cached line keyed by line address
  icache_pkg::way_idx_t line_way [icache_pkg::paddr_t];

  int errors;
  int miss_pulses;

  icache_top u_dut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .en_i            (en_i),
    .flush_i         (flush_i),
    .busy_o          (busy_o),
    .miss_o          (miss_o),
    .req_i           (req_i),
    .addr_i          (addr_i),
    .ready_o         (ready_o),
    .valid_o         (valid_o),
    .data_o          (data_o),
    .mem_req_o       (mem_req_o),
    .mem_ack_i       (mem_ack_i),
    .mem_paddr_o     (mem_paddr_o),
    .mem_nc_o        (mem_nc_o),
    .mem_way_o       (mem_way_o),
    .mem_rtrn_vld_i  (mem_rtrn_vld_i),
    .mem_rtrn_type_i (mem_rtrn_type_i),
    .mem_rtrn_data_i (mem_rtrn_data_i),
    .mem_inv_all_i   (mem_inv_all_i),
    .mem_inv_vld_i   (mem_inv_vld_i),
    .mem_inv_idx_i   (mem_inv_idx_i),
    .mem_inv_way_i   (mem_inv_way_i)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // outputs are sampled mid cycle at the falling edge
  always @(negedge clk_i) begin : count_miss
    if (rst_ni && miss_o) begin
      miss_pulses++;
    end
  end

  //////////////////////////////
  // helpers and compares
  //////////////////////////////

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic note_error(input string msg);
    $display("Error %s", msg);
    errors++;
  endtask

  task automatic check_word(input string name, input icache_pkg::word_t exp,
                            input icache_pkg::word_t act);
    if (exp !== act) begin
      $display("Mismatch %s data: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_paddr(input string name, input icache_pkg::paddr_t exp,
                             input icache_pkg::paddr_t act);
    if (exp !== act) begin
      $display("Mismatch %s mem_paddr_o: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Mismatch %s: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  function automatic icache_pkg::word_t model_word(input icache_pkg::paddr_t a);
    return {a[31:2], 2'b00} ^ MODEL_KEY;
  endfunction

  // NC returns repeat the one word in every slot
  function automatic icache_pkg::line_t build_line(input icache_pkg::paddr_t a, input logic nc);
    icache_pkg::line_t line;
    for (int i = 0; i < `ICACHE_LINE_BITS / `ICACHE_FETCH_BITS; i++) begin
      if (nc) begin
        line[i*`ICACHE_FETCH_BITS +: `ICACHE_FETCH_BITS] = model_word(a);
      end else begin
        line[i*`ICACHE_FETCH_BITS +: `ICACHE_FETCH_BITS] =
          model_word(a + icache_pkg::paddr_t'(4 * i));
      end
    end
    return line;
  endfunction

  //////////////////////////////
  // row actions
  //////////////////////////////

  task automatic fetch_word(input string name, input icache_pkg::paddr_t addr,
                            input outcome_e exp);
    icache_pkg::paddr_t   req_addr;
    icache_pkg::paddr_t   exp_paddr;
    icache_pkg::way_idx_t req_way;
    logic got_req;
    logic act_nc;
    logic exp_nc;
    int   pulses_before;
    int   wait_cyc;
    int   delay;
    pulses_before = miss_pulses;
    exp_nc        = (exp == E_NC);
    exp_paddr     = exp_nc ? {addr[31:2], 2'b00} : {addr[31:4], 4'h0};
    req_i         = 1'b1;
    addr_i        = addr;
    wait_cyc      = 0;
    @(negedge clk_i);
    while (!ready_o && wait_cyc < 100) begin
      @(negedge clk_i);
      wait_cyc++;
    end
    if (!ready_o) begin
      note_error($sformatf("%s: ready_o never rose, fetch was not taken", name));
      req_i = 1'b0;
      return;
    end
    // request taken at this edge
    next_cycle();
    req_i    = 1'b0;
    wait_cyc = 0;
    @(negedge clk_i);
    while (!valid_o && !mem_req_o && wait_cyc < 20) begin
      @(negedge clk_i);
      wait_cyc++;
    end
    // hit data and the memory request both belong to the first lookup cycle
    if ((valid_o || mem_req_o) && wait_cyc != 0) begin
      note_error($sformatf("%s: response came %0d cycles late", name, wait_cyc));
    end
    got_req = mem_req_o;
    if (exp != E_ANY) begin
      check_flag({name, " mem_req_o"}, exp != E_HIT, got_req);
    end
    if (valid_o && !mem_req_o) begin
      check_word(name, model_word(addr), data_o);
      next_cycle();
    end else if (mem_req_o) begin
      req_addr = mem_paddr_o;
      act_nc   = mem_nc_o;
      req_way  = mem_way_o;
      check_flag({name, " mem_nc_o"}, exp_nc, act_nc);
      check_paddr(name, exp_paddr, req_addr);
      // request must hold through a random ack latency
      delay = $urandom_range(5, 0);
      repeat (delay) begin
        next_cycle();
        @(negedge clk_i);
        if (!mem_req_o || mem_paddr_o !== req_addr || mem_nc_o !== act_nc ||
            mem_way_o !== req_way) begin
          note_error($sformatf("%s: mem_req_o dropped or its fields changed before ack",
                               name));
        end
      end
      next_cycle();
      mem_ack_i = 1'b1;
      @(negedge clk_i);
      if (!act_nc) begin
        line_way[exp_paddr] = mem_way_o;
      end
      next_cycle();
      mem_ack_i = 1'b0;
      delay     = $urandom_range(5, 0);
      repeat (delay) next_cycle();
      mem_rtrn_vld_i  = 1'b1;
      mem_rtrn_type_i = icache_pkg::IFILL;
      mem_rtrn_data_i = build_line(req_addr, act_nc);
      @(negedge clk_i);
      if (!valid_o) begin
        note_error($sformatf("%s: valid_o did not rise with the refill return", name));
      end else begin
        check_word(name, model_word(addr), data_o);
      end
      next_cycle();
      mem_rtrn_vld_i = 1'b0;
    end else begin
      note_error($sformatf("%s: neither valid_o nor mem_req_o rose", name));
      next_cycle();
    end
    check_count({name, " miss_o pulses"},
                (exp == E_MISS || (exp == E_ANY && got_req)) ? 1 : 0,
                miss_pulses - pulses_before);
  endtask

  // counts the busy cycles of one flush
  task automatic flush_wait(input string name);
    int n;
    int guard;
    n     = 0;
    guard = 0;
    @(negedge clk_i);
    while (!busy_o && guard < 4) begin
      @(negedge clk_i);
      guard++;
    end
    while (busy_o && n < 4 * `ICACHE_SETS) begin
      if (ready_o) begin
        note_error($sformatf("%s: ready_o high during flush", name));
      end
      n++;
      @(negedge clk_i);
    end
    check_count({name, " busy cycles"}, `ICACHE_SETS, n);
  endtask

  task automatic send_inv(input string name, input icache_pkg::paddr_t addr, input logic all);
    icache_pkg::paddr_t line_addr;
    line_addr       = {addr[31:4], 4'h0};
    mem_rtrn_vld_i  = 1'b1;
    mem_rtrn_type_i = icache_pkg::INV;
    mem_inv_all_i   = all;
    mem_inv_vld_i   = !all;
    mem_inv_idx_i   = addr[9:4];
    mem_inv_way_i   = '0;
    if (!all) begin
      if (line_way.exists(line_addr)) begin
        mem_inv_way_i = line_way[line_addr];
      end else begin
        note_error($sformatf("%s: no refill way recorded for this line", name));
      end
    end
    @(negedge clk_i);
    if (ready_o) begin
      note_error($sformatf("%s: ready_o high during invalidation", name));
    end
    next_cycle();
    mem_rtrn_vld_i = 1'b0;
    mem_inv_all_i  = 1'b0;
    mem_inv_vld_i  = 1'b0;
  endtask

  task automatic add_row(input kind_e kind, input icache_pkg::paddr_t addr, input outcome_e exp);
    row_kind.push_back(kind);
    row_addr.push_back(addr);
    row_exp.push_back(exp);
  endtask

  task automatic build_table();
    // everything goes out as NC while the cache is disabled
    add_row(K_FETCH, 32'h0000_1004, E_NC);
    add_row(K_FETCH, 32'h0000_1004, E_NC);
    add_row(K_FETCH, 32'h8000_0010, E_NC);
    // after enable one miss then hits in the same line
    add_row(K_ENABLE, 32'h0, E_NONE);
    add_row(K_FETCH, 32'h0000_1000, E_MISS);
    add_row(K_FETCH, 32'h0000_1004, E_HIT);
    add_row(K_FETCH, 32'h0000_100C, E_HIT);
    add_row(K_FETCH, 32'h0000_1008, E_HIT);
    // io region
    add_row(K_FETCH, 32'h8000_0020, E_NC);
    add_row(K_FETCH, 32'h8000_0020, E_NC);
    // set 1 invalidations
    // the second line lands in way 1 and only that way is dropped
    add_row(K_FETCH, 32'h0000_2010, E_MISS);
    add_row(K_FETCH, 32'h0000_3010, E_MISS);
    add_row(K_INV_WAY, 32'h0000_3010, E_NONE);
    add_row(K_FETCH, 32'h0000_3014, E_MISS);
    add_row(K_FETCH, 32'h0000_2018, E_HIT);
    add_row(K_INV_ALL, 32'h0000_2010, E_NONE);
    add_row(K_FETCH, 32'h0000_2010, E_MISS);
    add_row(K_FETCH, 32'h0000_3014, E_MISS);
    // flush drops everything
    add_row(K_FETCH, 32'h0000_1000, E_HIT);
    add_row(K_FLUSH, 32'h0, E_NONE);
    add_row(K_FETCH, 32'h0000_1004, E_MISS);
    add_row(K_FETCH, 32'h0000_2010, E_MISS);
    // five lines into set 5 with four ways
    for (int i = 0; i < 5; i++) begin
      add_row(K_FETCH, 32'h0001_0050 + icache_pkg::paddr_t'(i * 32'h400), E_MISS);
    end
    // same five lines again, other words inside each line
    for (int i = 0; i < 5; i++) begin
      add_row(K_FETCH, 32'h0001_0050 + icache_pkg::paddr_t'(i * 32'h400 + (i % 4) * 4),
              E_ANY);
    end
    // cached lines are bypassed once disabled again
    add_row(K_DISABLE, 32'h0, E_NONE);
    add_row(K_FETCH, 32'h0000_1004, E_NC);
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin : main
    int    row_errors;
    int    failed_rows;
    kind_e kind;
    string name;
    rst_ni          = 1'b0;
    en_i            = 1'b0;
    flush_i         = 1'b0;
    req_i           = 1'b0;
    addr_i          = '0;
    mem_ack_i       = 1'b0;
    mem_rtrn_vld_i  = 1'b0;
    mem_rtrn_type_i = icache_pkg::IFILL;
    mem_rtrn_data_i = '0;
    mem_inv_all_i   = 1'b0;
    mem_inv_vld_i   = 1'b0;
    mem_inv_idx_i   = '0;
    mem_inv_way_i   = '0;
    failed_rows     = 0;
    void'($urandom(8643));
    build_table();
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    next_cycle();
    for (int i = 0; i < row_kind.size(); i++) begin
      row_errors = errors;
      kind       = row_kind[i];
      name       = $sformatf("row %0d %s", i, kind.name());
      case (kind)
        K_FETCH: fetch_word(name, row_addr[i], row_exp[i]);
        K_ENABLE: begin
          en_i = 1'b1;
          next_cycle();
          flush_wait(name);
          next_cycle();
        end
        K_DISABLE: begin
          en_i = 1'b0;
          next_cycle();
          next_cycle();
        end
        K_FLUSH: begin
          flush_i = 1'b1;
          next_cycle();
          flush_i = 1'b0;
          flush_wait(name);
          next_cycle();
        end
        K_INV_WAY: send_inv(name, row_addr[i], 1'b0);
        default: send_inv(name, row_addr[i], 1'b1);
      endcase
      if (errors != row_errors) begin
        failed_rows++;
      end
      $display("%s addr %h: %s", name, row_addr[i], (errors == row_errors) ? "ok" : "FAILED");
    end
    $display("rows %0d, failed rows %0d, errors %0d", row_kind.size(), failed_rows, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // limit scales with the table length
  initial begin : watchdog
    int limit;
    #1;
    limit = row_kind.size() * 200 + 20;
    repeat (limit) @(posedge clk_i);
    $display("Error watchdog expired after %0d cycles, the run did not finish", limit);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
icache_pkg.sv
icache_array_if.sv
icache_sram.sv
icache_ways.sv
icache_repl.sv
icache_ctrl.sv
icache_top.sv
tb_icache.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the instruction cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_icache -f verilog.f -o sim_icache

./obj_dir/sim_icache > sim.log 2>&1 || true
cat sim.log

if grep -qx "sim passed" sim.log; then
  exit 0
fi
exit 1
